// File: files.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/regfile.sv
rtl/imm_gen.sv
rtl/data_memory.sv
rtl/control.sv
rtl/cpu.sv
tests/cpu_asserts.sv
tests/cpu_tb.sv

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::XLEN-1:0] a,
    input  logic [cpu_pkg::XLEN-1:0] b,
    input  cpu_pkg::alu_op_e         alu_control,
    output logic [cpu_pkg::XLEN-1:0] result,
    output logic                     zero
);

    logic [4:0] shamt;

    // RV32 shifts only look at five bits
    assign shamt = b[4:0];

    always_comb begin
        case (alu_control)
            cpu_pkg::alu_add:  result = a + b;
            cpu_pkg::alu_sub:  result = a - b;
            cpu_pkg::alu_and:  result = a & b;
            cpu_pkg::alu_or:   result = a | b;
            cpu_pkg::alu_xor:  result = a ^ b;
            cpu_pkg::alu_sll:  result = a << shamt;
            cpu_pkg::alu_srl:  result = a >> shamt;
            cpu_pkg::alu_sra:  result = $signed(a) >>> shamt;
            cpu_pkg::alu_slt: begin
                result = {{(cpu_pkg::XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            cpu_pkg::alu_sltu: begin
                result = {{(cpu_pkg::XLEN-1){1'b0}}, (a < b)};
            end
            default: result = '0;
        endcase
    end

    // Equal operands for beq
    assign zero = (result == '0);

endmodule

// File: rtl/control.sv
`timescale 1ns/1ps

module control (
    input  logic [6:0]      op,
    input  logic [2:0]      func3,
    input  logic [6:0]      func7,
    input  logic            alu_zero,
    output cpu_pkg::ctrl_t  ctrl,
    output logic            pc_source
);

    cpu_pkg::ctrl_t   main_ctrl;
    cpu_pkg::alu_op_e alu_sel;
    logic             branch;
    logic             jump;
    logic             shift_illegal;

    // Main decoder
    always_comb begin
        // Safe defaults so unknown opcodes leave state untouched
        main_ctrl.alu_control = cpu_pkg::alu_add;
        main_ctrl.imm_source = cpu_pkg::imm_i;
        main_ctrl.mem_write = 1'b0;
        main_ctrl.reg_write = 1'b0;
        main_ctrl.alu_source = 1'b0;
        main_ctrl.write_back_source = cpu_pkg::wb_alu;
        main_ctrl.second_add_source = 1'b0;
        branch = 1'b0;
        jump = 1'b0;

        case (op)
            cpu_pkg::op_load: begin
                main_ctrl.reg_write = 1'b1;
                main_ctrl.alu_source = 1'b1;
                main_ctrl.write_back_source = cpu_pkg::wb_mem;
            end
            cpu_pkg::op_imm: begin
                main_ctrl.reg_write = 1'b1;
                main_ctrl.alu_source = 1'b1;
            end
            cpu_pkg::op_store: begin
                main_ctrl.imm_source = cpu_pkg::imm_s;
                main_ctrl.mem_write = 1'b1;
                main_ctrl.alu_source = 1'b1;
            end
            cpu_pkg::op_reg: begin
                main_ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_branch: begin
                // Operands compared by subtraction in the ALU
                main_ctrl.imm_source = cpu_pkg::imm_b;
                branch = 1'b1;
            end
            cpu_pkg::op_jal: begin
                main_ctrl.reg_write = 1'b1;
                main_ctrl.imm_source = cpu_pkg::imm_j;
                main_ctrl.write_back_source = cpu_pkg::wb_pc4;
                jump = 1'b1;
            end
            cpu_pkg::op_lui: begin
                main_ctrl.reg_write = 1'b1;
                main_ctrl.imm_source = cpu_pkg::imm_u;
                main_ctrl.write_back_source = cpu_pkg::wb_upper;
                main_ctrl.second_add_source = 1'b1;
            end
            cpu_pkg::op_auipc: begin
                main_ctrl.reg_write = 1'b1;
                main_ctrl.imm_source = cpu_pkg::imm_u;
                main_ctrl.write_back_source = cpu_pkg::wb_upper;
            end
            default: begin
            end
        endcase
    end

    // ALU decoder
    always_comb begin
        alu_sel = cpu_pkg::alu_add;
        shift_illegal = 1'b0;

        if (branch) begin
            alu_sel = cpu_pkg::alu_sub;
        end else if (op == cpu_pkg::op_reg || op == cpu_pkg::op_imm) begin
            case (func3)
                3'b000: begin
                    // Only the register form has a sub
                    if (op == cpu_pkg::op_reg && func7[5]) begin
                        alu_sel = cpu_pkg::alu_sub;
                    end
                end
                3'b001: begin
                    alu_sel = cpu_pkg::alu_sll;
                    shift_illegal = (op == cpu_pkg::op_imm) && (func7 != 7'b0000000);
                end
                3'b010: alu_sel = cpu_pkg::alu_slt;
                3'b011: alu_sel = cpu_pkg::alu_sltu;
                3'b100: alu_sel = cpu_pkg::alu_xor;
                3'b101: begin
                    if (func7 == 7'b0100000) begin
                        alu_sel = cpu_pkg::alu_sra;
                    end else begin
                        alu_sel = cpu_pkg::alu_srl;
                    end
                    shift_illegal = (op == cpu_pkg::op_imm) &&
                                    (func7 != 7'b0000000) && (func7 != 7'b0100000);
                end
                3'b110: alu_sel = cpu_pkg::alu_or;
                3'b111: alu_sel = cpu_pkg::alu_and;
                default: alu_sel = cpu_pkg::alu_add;
            endcase
        end
    end

    // Merge both decoders and kill the write on a malformed shamt field
    always_comb begin
        ctrl = main_ctrl;
        ctrl.alu_control = alu_sel;
        if (shift_illegal) begin
            ctrl.reg_write = 1'b0;
        end
    end

    assign pc_source = (alu_zero & branch) | jump;

endmodule

// File: rtl/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              instr,
    output logic [cpu_pkg::XLEN-1:0] instr_addr,
    output cpu_pkg::retire_t         retire
);

    logic [cpu_pkg::XLEN-1:0] pc;
    logic [cpu_pkg::XLEN-1:0] pc_plus4;
    logic [cpu_pkg::XLEN-1:0] pc_target;
    logic [cpu_pkg::XLEN-1:0] pc_next;
    logic [6:0]               op;
    logic [2:0]               func3;
    logic [6:0]               func7;
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic [4:0]               rd;
    cpu_pkg::ctrl_t           ctrl;
    logic                     pc_source;
    logic                     alu_zero;
    logic [cpu_pkg::XLEN-1:0] imm;
    logic [cpu_pkg::XLEN-1:0] rs1_data;
    logic [cpu_pkg::XLEN-1:0] rs2_data;
    logic [cpu_pkg::XLEN-1:0] alu_b;
    logic [cpu_pkg::XLEN-1:0] alu_result;
    logic [cpu_pkg::XLEN-1:0] mem_read_data;
    logic [cpu_pkg::XLEN-1:0] upper_value;
    logic [cpu_pkg::XLEN-1:0] wb_data;

    // Instruction fields
    assign op = instr[6:0];
    assign rd = instr[11:7];
    assign func3 = instr[14:12];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign func7 = instr[31:25];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= cpu_pkg::RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4 = pc + 32'd4;
    assign pc_target = pc + imm;
    assign pc_next = pc_source ? pc_target : pc_plus4;
    assign instr_addr = pc;

    control u_control (
        .op        (op),
        .func3     (func3),
        .func7     (func7),
        .alu_zero  (alu_zero),
        .ctrl      (ctrl),
        .pc_source (pc_source)
    );

    imm_gen u_imm_gen (.instr(instr), .imm_source(ctrl.imm_source), .imm(imm));

    regfile u_regfile (
        .clk          (clk),
        .reset        (reset),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .write_enable (ctrl.reg_write),
        .write_data   (wb_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    assign alu_b = ctrl.alu_source ? imm : rs2_data;

    alu u_alu (
        .a           (rs1_data),
        .b           (alu_b),
        .alu_control (ctrl.alu_control),
        .result      (alu_result),
        .zero        (alu_zero)
    );

    data_memory u_data_memory (
        .clk          (clk),
        .reset        (reset),
        .addr         (alu_result),
        .write_enable (ctrl.mem_write),
        .write_data   (rs2_data),
        .read_data    (mem_read_data)
    );

    // lui takes the immediate alone, auipc adds the pc
    assign upper_value = ctrl.second_add_source ? imm : pc_target;

    always_comb begin
        case (ctrl.write_back_source)
            cpu_pkg::wb_alu:   wb_data = alu_result;
            cpu_pkg::wb_mem:   wb_data = mem_read_data;
            cpu_pkg::wb_pc4:   wb_data = pc_plus4;
            cpu_pkg::wb_upper: wb_data = upper_value;
            default:           wb_data = alu_result;
        endcase
    end

    always_comb begin
        retire.valid = ctrl.reg_write & ~reset;
        retire.rd = rd;
        retire.data = wb_data;
    end

endmodule

// File: rtl/cpu_pkg.sv
package cpu_pkg;

    // Core sizes
    localparam int XLEN = 32;
    localparam int REG_COUNT = 32;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_ADDR_BITS = $clog2(DMEM_WORDS);
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b0001,
        alu_and  = 4'b0010,
        alu_or   = 4'b0011,
        alu_sll  = 4'b0100,
        alu_slt  = 4'b0101,
        alu_srl  = 4'b0110,
        alu_sltu = 4'b0111,
        alu_xor  = 4'b1000,
        alu_sra  = 4'b1001
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i = 3'b000,
        imm_s = 3'b001,
        imm_b = 3'b010,
        imm_j = 3'b011,
        imm_u = 3'b100
    } imm_kind_e;

    typedef enum logic [1:0] {
        wb_alu   = 2'b00,
        wb_mem   = 2'b01,
        wb_pc4   = 2'b10,
        wb_upper = 2'b11
    } wb_source_e;

    // Decoded control for one instruction
    typedef struct packed {
        alu_op_e    alu_control;
        imm_kind_e  imm_source;
        logic       mem_write;
        logic       reg_write;
        logic       alu_source;
        wb_source_e write_back_source;
        logic       second_add_source;
    } ctrl_t;

    // Writeback trace of the instruction in flight
    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } retire_t;

endpackage

// File: rtl/data_memory.sv
`timescale 1ns/1ps

module data_memory (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [cpu_pkg::XLEN-1:0] addr,
    input  logic                     write_enable,
    input  logic [cpu_pkg::XLEN-1:0] write_data,
    output logic [cpu_pkg::XLEN-1:0] read_data
);

    logic [cpu_pkg::XLEN-1:0]         mem [cpu_pkg::DMEM_WORDS];
    logic [cpu_pkg::DMEM_ADDR_BITS-1:0] index;

    // Word index with the byte offset dropped
    assign index = addr[cpu_pkg::DMEM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cpu_pkg::DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (write_enable) begin
            mem[index] <= write_data;
        end
    end

    assign read_data = mem[index];

endmodule

// File: rtl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  logic [31:0]              instr,
    input  cpu_pkg::imm_kind_e       imm_source,
    output logic [cpu_pkg::XLEN-1:0] imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_source)
            cpu_pkg::imm_i: imm = {{20{sign}}, instr[31:20]};
            cpu_pkg::imm_s: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            cpu_pkg::imm_b: begin
                // Branch offsets are in halfwords
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            cpu_pkg::imm_j: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            // Upper immediate with zero low bits
            cpu_pkg::imm_u: imm = {instr[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    input  logic [4:0]               rd,
    input  logic                     write_enable,
    input  logic [cpu_pkg::XLEN-1:0] write_data,
    output logic [cpu_pkg::XLEN-1:0] rs1_data,
    output logic [cpu_pkg::XLEN-1:0] rs2_data
);

    logic [cpu_pkg::XLEN-1:0] regs [cpu_pkg::REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd != 5'd0) begin
            regs[rd] <= write_data;
        end
    end

    // x0 reads as zero
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -f files.f

output=$(./obj_dir/Vcpu_tb) || true
echo "$output"

if echo "$output" | grep -q "^RESULT: PASS$"; then
    exit 0
else
    exit 1
fi

// File: tests/cpu_asserts.sv
`timescale 1ns/1ps

module cpu_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic [cpu_pkg::XLEN-1:0] pc,
    input cpu_pkg::retire_t         retire,
    input cpu_pkg::ctrl_t           ctrl
);

    // Fetch stays on word boundaries
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // A store never writes back
    store_no_retire: assert property (@(posedge clk) disable iff (reset)
        !(retire.valid && ctrl.mem_write))
        else $error("retire valid during a store");

    // First cycle out of reset fetches from the reset vector
    pc_after_reset: assert property (@(posedge clk) $fell(reset) |-> pc == cpu_pkg::RESET_PC)
        else $error("pc does not start at the reset vector");

endmodule

bind cpu cpu_asserts u_cpu_asserts (
    .clk    (clk),
    .reset  (reset),
    .pc     (pc),
    .retire (retire),
    .ctrl   (ctrl)
);

// File: tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    // One program row per instruction word
    typedef struct packed {
        logic [31:0] word;
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] next_pc;
    } row_t;

    localparam int ROWS = 64;
    localparam int RESET_CYCLES = 5;

    logic             clk = 1'b0;
    logic             reset = 1'b1;
    logic [31:0]      instr = 32'h0000_0000;
    logic [31:0]      instr_addr;
    cpu_pkg::retire_t retire;

    row_t        program_rows [ROWS];
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [cpu_pkg::DMEM_WORDS];
    logic [31:0] fill_pc;
    int          steps = 0;
    int          cycle_limit = 0;
    int          cycles = 0;

    cpu DUT (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instr_addr (instr_addr),
        .retire     (retire)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: the program did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [11:0] random_imm();
        return 12'($urandom);
    endfunction

    // RV32I integer result by funct3 with alt selecting sub and sra
    function automatic logic [31:0] compute_result(input logic [2:0] f3, input logic alt,
                                                   input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic put_row(input logic [31:0] word, input logic valid, input logic [4:0] rd,
                           input logic [31:0] data, input logic [31:0] next_pc);
        program_rows[fill_pc[7:2]] = {word, valid, rd, data, next_pc};
        if (valid && rd != 5'd0) begin
            model_regs[rd] = data;
        end
        fill_pc = next_pc;
        steps++;
    endtask

    task automatic reg_op(input logic [2:0] f3, input logic alt, input int rd, input int rs1,
                          input int rs2);
        logic [31:0] word;
        logic [31:0] result;
        word = {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
        result = compute_result(f3, alt, model_regs[rs1], model_regs[rs2]);
        put_row(word, 1'b1, 5'(rd), result, fill_pc + 32'd4);
    endtask

    task automatic imm_op(input logic [2:0] f3, input int rd, input int rs1,
                          input logic [11:0] imm);
        logic [31:0] word;
        logic [31:0] result;
        logic        alt;
        logic        legal;
        word = {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
        // Shift immediates carry funct7 in imm[11:5]
        alt = (f3 == 3'b101) && (imm[11:5] == 7'b0100000);
        legal = 1'b1;
        if (f3 == 3'b001) begin
            legal = (imm[11:5] == 7'b0);
        end
        if (f3 == 3'b101) begin
            legal = (imm[11:5] == 7'b0) || alt;
        end
        result = compute_result(f3, alt, model_regs[rs1], {{20{imm[11]}}, imm});
        put_row(word, legal, 5'(rd), result, fill_pc + 32'd4);
    endtask

    task automatic upper_imm(input logic pc_relative, input int rd, input logic [19:0] imm);
        logic [31:0] word;
        word = {imm, 5'(rd), pc_relative ? 7'b0010111 : 7'b0110111};
        put_row(word, 1'b1, 5'(rd), pc_relative ? fill_pc + {imm, 12'b0} : {imm, 12'b0},
                fill_pc + 32'd4);
    endtask

    task automatic store_word(input int rs2, input int rs1, input int offset);
        logic [11:0] off;
        logic [31:0] addr;
        off = 12'(offset);
        addr = model_regs[rs1] + {{20{off[11]}}, off};
        model_mem[addr[7:2]] = model_regs[rs2];
        put_row({off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], 7'b0100011}, 1'b0, 5'd0,
                32'd0, fill_pc + 32'd4);
    endtask

    task automatic load_word(input int rd, input int rs1, input int offset);
        logic [11:0] off;
        logic [31:0] addr;
        off = 12'(offset);
        addr = model_regs[rs1] + {{20{off[11]}}, off};
        put_row({off, 5'(rs1), 3'b010, 5'(rd), 7'b0000011}, 1'b1, 5'(rd),
                model_mem[addr[7:2]], fill_pc + 32'd4);
    endtask

    task automatic branch_eq(input int rs1, input int rs2, input int offset);
        logic [12:0] off;
        logic [31:0] target;
        off = 13'(offset);
        target = fill_pc + 32'd4;
        if (model_regs[rs1] == model_regs[rs2]) begin
            target = fill_pc + {{19{off[12]}}, off};
        end
        put_row({off[12], off[10:5], 5'(rs2), 5'(rs1), 3'b000, off[4:1], off[11], 7'b1100011},
                1'b0, 5'd0, 32'd0, target);
    endtask

    task automatic jump_link(input int rd, input int offset);
        logic [20:0] off;
        off = 21'(offset);
        put_row({off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111}, 1'b1, 5'(rd),
                fill_pc + 32'd4, fill_pc + {{11{off[20]}}, off});
    endtask

    initial begin
        logic [31:0] pc;
        row_t        row;
        void'($urandom(54137));
        for (int i = 0; i < ROWS; i++) begin
            program_rows[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < cpu_pkg::DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        fill_pc = cpu_pkg::RESET_PC;

        // Immediate forms with a negative value in x2
        imm_op(3'b000, 1, 0, random_imm());
        imm_op(3'b000, 2, 0, 12'hffb);
        imm_op(3'b111, 3, 1, random_imm());
        imm_op(3'b110, 4, 1, random_imm());
        imm_op(3'b100, 5, 2, random_imm());
        imm_op(3'b010, 6, 2, random_imm());
        imm_op(3'b011, 7, 2, random_imm());
        imm_op(3'b001, 21, 1, 12'h004);
        imm_op(3'b101, 22, 2, 12'h402);
        upper_imm(1'b0, 8, 20'($urandom));
        upper_imm(1'b1, 9, 20'($urandom));
        // Register forms
        reg_op(3'b000, 1'b0, 10, 1, 2);
        reg_op(3'b000, 1'b1, 11, 2, 1);
        reg_op(3'b111, 1'b0, 12, 1, 2);
        reg_op(3'b110, 1'b0, 13, 1, 2);
        reg_op(3'b100, 1'b0, 14, 1, 2);
        reg_op(3'b010, 1'b0, 15, 2, 1);
        reg_op(3'b011, 1'b0, 16, 2, 1);
        // Shift amount 35 masks down to 3
        imm_op(3'b000, 17, 0, 12'd35);
        reg_op(3'b001, 1'b0, 18, 2, 17);
        reg_op(3'b101, 1'b0, 19, 2, 17);
        reg_op(3'b101, 1'b1, 20, 2, 17);
        // Memory round trip
        imm_op(3'b000, 23, 0, 12'd16);
        store_word(10, 23, 0);
        store_word(20, 23, 8);
        load_word(24, 23, 0);
        load_word(25, 23, 8);
        load_word(26, 23, 4);
        load_word(27, 0, 24);
        // Taken beq, never-taken beq, then jal
        branch_eq(24, 10, 8);
        branch_eq(2, 0, 8);
        jump_link(27, 8);
        // Unknown opcode, then slli and srli with bad funct7
        put_row({20'h0, 5'd10, 7'b1111111}, 1'b0, 5'd0, 32'd0, fill_pc + 32'd4);
        imm_op(3'b001, 10, 1, 12'h423);
        imm_op(3'b101, 11, 2, 12'h023);
        reg_op(3'b000, 1'b0, 28, 10, 0);
        reg_op(3'b000, 1'b0, 29, 11, 0);
        // Write to x0 is dropped
        imm_op(3'b000, 0, 1, 12'd5);
        reg_op(3'b000, 1'b0, 30, 0, 1);

        cycle_limit = 2 * steps + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        pc = cpu_pkg::RESET_PC;
        instr <= program_rows[pc[7:2]].word;
        for (int step = 0; step < steps; step++) begin
            row = program_rows[pc[7:2]];
            @(negedge clk);
            check_value("instr_addr", pc, instr_addr);
            check_value("retire.valid", 32'(row.valid), 32'(retire.valid));
            if (row.valid) begin
                check_value("retire.rd", 32'(row.rd), 32'(retire.rd));
                check_value("retire.data", row.data, retire.data);
            end
            @(posedge clk);
            pc = row.next_pc;
            instr <= program_rows[pc[7:2]].word;
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule
